// ==== rv_pkg.sv ====
// Shared definitions for the RV32I pipeline
// Widths, opcodes, ALU codes, write-back and forwarding selects
// Instruction format union used by decode and the testbench
package rv_pkg;

  localparam int xlen           = 32;
  localparam int reg_addr_bits  = 5;
  localparam int dmem_words     = 256;
  localparam int dmem_addr_bits = $clog2(dmem_words);  // Word index, addr bits 9:2

  // Major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_op_imm = 7'b0010011;
  localparam logic [6:0] op_op     = 7'b0110011;

  // ALU operation codes
  localparam logic [3:0] alu_add  = 4'd0;
  localparam logic [3:0] alu_sub  = 4'd1;
  localparam logic [3:0] alu_sll  = 4'd2;
  localparam logic [3:0] alu_slt  = 4'd3;
  localparam logic [3:0] alu_sltu = 4'd4;
  localparam logic [3:0] alu_xor  = 4'd5;
  localparam logic [3:0] alu_srl  = 4'd6;
  localparam logic [3:0] alu_sra  = 4'd7;
  localparam logic [3:0] alu_or   = 4'd8;
  localparam logic [3:0] alu_and  = 4'd9;

  // Write-back source
  localparam logic [1:0] wb_alu = 2'd0;
  localparam logic [1:0] wb_mem = 2'd1;
  localparam logic [1:0] wb_pc4 = 2'd2;

  // Operand forwarding source
  localparam logic [1:0] fwd_none  = 2'b00;
  localparam logic [1:0] fwd_exmem = 2'b10;  // Previous instruction, in EX/MEM
  localparam logic [1:0] fwd_memwb = 2'b01;  // Two back, on the write-back port

  // Instruction formats, MSB first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // One instruction word, six views
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } rv_instr_t;

endpackage

// ==== rv_fetch.sv ====
// Fetch stage
// Program counter, next-PC select and the IF/ID register
`timescale 1ns/100ps

module rv_fetch import rv_pkg::*; (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            stall,
  input  logic            redirect,
  input  logic [xlen-1:0] redirect_target,
  input  logic [31:0]     imem_rdata,
  output logic [xlen-1:0] imem_addr,
  output logic [xlen-1:0] if_pc,
  output logic [xlen-1:0] if_instr,
  output logic            if_valid
);

  logic [xlen-1:0] pc;
  logic [xlen-1:0] pc_next;

  assign imem_addr = pc;  // Fetch port sees the PC directly

  // Redirect wins over stall
  always_comb begin
    if (redirect)
      pc_next = redirect_target;
    else if (stall)
      pc_next = pc;
    else
      pc_next = pc + xlen'(4);
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n)
      pc <= '0;  // Reset vector
    else
      pc <= pc_next;
  end

  // IF/ID valid, killed by a taken branch or jump
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n)
      if_valid <= 1'b0;
    else if (redirect)
      if_valid <= 1'b0;
    else if (!stall)
      if_valid <= 1'b1;
  end

  // IF/ID payload
  always_ff @(posedge clk) begin
    if (!stall) begin
      if_pc    <= pc;
      if_instr <= imem_rdata;
    end
  end

  // Redirect targets from execute must keep the PC on a word boundary
  a_pc_aligned: assert property (@(posedge clk) disable iff (!reset_n)
    imem_addr[1:0] == 2'b00);

endmodule

// ==== rv_regfile.sv ====
// Register file, 31 writable registers with x0 fixed at zero
// Write-back to decode bypass on both read ports
`timescale 1ns/100ps

module rv_regfile import rv_pkg::*; (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic [reg_addr_bits-1:0] rs1_addr,
  input  logic [reg_addr_bits-1:0] rs2_addr,
  input  logic                     wb_valid,
  input  logic [reg_addr_bits-1:0] wb_rd,
  input  logic [xlen-1:0]          wb_data,
  output logic [xlen-1:0]          rs1_data,
  output logic [xlen-1:0]          rs2_data
);

  logic [xlen-1:0] regs [1:31];  // No storage behind x0

  always_ff @(posedge clk) begin
    if (wb_valid)
      regs[wb_rd] <= wb_data;
  end

  // Same-cycle write returns the new value
  always_comb begin
    if (rs1_addr == '0)
      rs1_data = '0;
    else if (wb_valid && wb_rd == rs1_addr)
      rs1_data = wb_data;
    else
      rs1_data = regs[rs1_addr];

    if (rs2_addr == '0)
      rs2_data = '0;
    else if (wb_valid && wb_rd == rs2_addr)
      rs2_data = wb_data;
    else
      rs2_data = regs[rs2_addr];
  end

  // Memory stage filters x0 writes before they reach here
  a_no_x0_write: assert property (@(posedge clk) disable iff (!reset_n)
    wb_valid |-> wb_rd != '0);

endmodule

// ==== rv_decode.sv ====
// Decode stage
// Field extraction, immediates, control, load-use stall, ID/EX register
`timescale 1ns/100ps

module rv_decode import rv_pkg::*; (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic [xlen-1:0]          if_pc,
  input  logic [xlen-1:0]          if_instr,
  input  logic                     if_valid,
  input  logic                     redirect,
  output logic [reg_addr_bits-1:0] rs1_addr,
  output logic [reg_addr_bits-1:0] rs2_addr,
  input  logic [xlen-1:0]          rs1_data,
  input  logic [xlen-1:0]          rs2_data,
  output logic                     stall,
  output logic [xlen-1:0]          ex_pc,
  output logic [xlen-1:0]          ex_rs1_data,
  output logic [xlen-1:0]          ex_rs2_data,
  output logic [reg_addr_bits-1:0] ex_rs1,
  output logic [reg_addr_bits-1:0] ex_rs2,
  output logic [reg_addr_bits-1:0] ex_rd,
  output logic [xlen-1:0]          ex_imm,
  output logic [2:0]               ex_funct3,
  output logic [3:0]               ex_alu_op,
  output logic                     ex_alu_src_imm,
  output logic [6:0]               ex_opcode,
  output logic                     ex_mem_read,
  output logic                     ex_mem_write,
  output logic                     ex_reg_write,
  output logic [1:0]               ex_wb_sel,
  output logic                     ex_valid
);

  rv_instr_t       instr;
  logic [6:0]      opcode;
  logic [xlen-1:0] imm;
  logic [3:0]      alu_op;
  logic            alu_src_imm;
  logic            mem_read;
  logic            mem_write;
  logic            reg_write;
  logic [1:0]      wb_sel;
  logic            uses_rs1;
  logic            uses_rs2;

  // alt picks SUB over ADD and SRA over SRL
  function automatic logic [3:0] alu_decode(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign instr  = if_instr;
  assign opcode = instr.r.opcode;

  // Unused source fields read as x0, so they never stall or forward
  assign uses_rs1 = !(opcode inside {op_lui, op_auipc, op_jal});
  assign uses_rs2 = opcode inside {op_op, op_branch, op_store};
  assign rs1_addr = uses_rs1 ? instr.r.rs1 : '0;
  assign rs2_addr = uses_rs2 ? instr.r.rs2 : '0;

  // Sign-extended immediate for each format
  always_comb begin
    case (opcode)
      op_lui, op_auipc: imm = {instr.u.imm_31_12, 12'b0};
      op_jal:    imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                        instr.j.imm_11, instr.j.imm_10_1, 1'b0};
      op_branch: imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                        instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
      op_store:  imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
      default:   imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};  // I-type
    endcase
  end

  // Control
  always_comb begin
    alu_op      = alu_add;  // Address and upper-immediate adds
    alu_src_imm = 1'b1;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    reg_write   = 1'b0;
    wb_sel      = wb_alu;
    case (opcode)
      op_lui, op_auipc: reg_write = 1'b1;
      op_jal, op_jalr: begin
        reg_write = 1'b1;
        wb_sel    = wb_pc4;  // Link address
      end
      op_load: begin
        mem_read  = 1'b1;
        reg_write = 1'b1;
        wb_sel    = wb_mem;
      end
      op_store:  mem_write = 1'b1;
      op_branch: alu_src_imm = 1'b0;  // Compare done outside the ALU
      op_op_imm: begin
        reg_write = 1'b1;
        alu_op    = alu_decode(instr.r.funct3, instr.r.funct3 == 3'b101 && instr.r.funct7[5]);
      end
      op_op: begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b0;
        alu_op      = alu_decode(instr.r.funct3, instr.r.funct7[5]);
      end
      default: ;  // No side effects for unknown opcodes
    endcase
  end

  // Load in EX whose result is needed here
  assign stall = if_valid && ex_valid && ex_mem_read && ex_rd != '0 &&
                 (ex_rd == rs1_addr || ex_rd == rs2_addr);

  // Bubble into ID/EX on stall or redirect
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n)
      ex_valid <= 1'b0;
    else
      ex_valid <= if_valid && !stall && !redirect;
  end

  always_ff @(posedge clk) begin
    ex_pc          <= if_pc;
    ex_rs1_data    <= rs1_data;
    ex_rs2_data    <= rs2_data;
    ex_rs1         <= rs1_addr;
    ex_rs2         <= rs2_addr;
    ex_rd          <= instr.r.rd;
    ex_imm         <= imm;
    ex_funct3      <= instr.r.funct3;
    ex_alu_op      <= alu_op;
    ex_alu_src_imm <= alu_src_imm;
    ex_opcode      <= opcode;
    ex_mem_read    <= mem_read;
    ex_mem_write   <= mem_write;
    ex_reg_write   <= reg_write;
    ex_wb_sel      <= wb_sel;
  end

  // A flush empties IF/ID too, so neither wrong-path slot reaches ID/EX
  a_flush_ifid: assert property (@(posedge clk) disable iff (!reset_n)
    redirect |=> !if_valid);

  // The stalled instruction is still waiting in IF/ID after its bubble
  a_stall_hold: assert property (@(posedge clk) disable iff (!reset_n)
    stall |=> if_valid && $stable(if_instr));

endmodule

// ==== rv_execute.sv ====
// Execute stage
// Forwarding, operand select, ALU, branch decision, jump targets,
// EX/MEM register
`timescale 1ns/100ps

module rv_execute import rv_pkg::*; (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic [xlen-1:0]          ex_pc,
  input  logic [xlen-1:0]          ex_rs1_data,
  input  logic [xlen-1:0]          ex_rs2_data,
  input  logic [reg_addr_bits-1:0] ex_rs1,
  input  logic [reg_addr_bits-1:0] ex_rs2,
  input  logic [reg_addr_bits-1:0] ex_rd,
  input  logic [xlen-1:0]          ex_imm,
  input  logic [2:0]               ex_funct3,
  input  logic [3:0]               ex_alu_op,
  input  logic                     ex_alu_src_imm,
  input  logic [6:0]               ex_opcode,
  input  logic                     ex_mem_read,
  input  logic                     ex_mem_write,
  input  logic                     ex_reg_write,
  input  logic [1:0]               ex_wb_sel,
  input  logic                     ex_valid,
  input  logic                     wb_valid,
  input  logic [reg_addr_bits-1:0] wb_rd,
  input  logic [xlen-1:0]          wb_data,
  output logic                     redirect,
  output logic [xlen-1:0]          redirect_target,
  output logic [xlen-1:0]          mem_alu_result,
  output logic [xlen-1:0]          mem_store_data,
  output logic [reg_addr_bits-1:0] mem_rd,
  output logic                     mem_read,
  output logic                     mem_write,
  output logic                     mem_reg_write,
  output logic [1:0]               mem_wb_sel,
  output logic [xlen-1:0]          mem_pc4,
  output logic                     mem_valid
);

  logic            exmem_ok;
  logic [1:0]      fwd_a;
  logic [1:0]      fwd_b;
  logic [xlen-1:0] rs1_val;
  logic [xlen-1:0] rs2_val;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_result;
  logic            take;

  // ====================================================================
  // Forwarding
  // ====================================================================
  // EX/MEM only holds a usable value for ALU results, never a load
  assign exmem_ok = mem_valid && mem_reg_write && mem_wb_sel == wb_alu && mem_rd != '0;

  assign fwd_a = (exmem_ok && mem_rd == ex_rs1) ? fwd_exmem :
                 (wb_valid && wb_rd == ex_rs1)  ? fwd_memwb : fwd_none;
  assign fwd_b = (exmem_ok && mem_rd == ex_rs2) ? fwd_exmem :
                 (wb_valid && wb_rd == ex_rs2)  ? fwd_memwb : fwd_none;

  always_comb begin
    case (fwd_a)
      fwd_exmem: rs1_val = mem_alu_result;
      fwd_memwb: rs1_val = wb_data;
      default:   rs1_val = ex_rs1_data;
    endcase
    case (fwd_b)
      fwd_exmem: rs2_val = mem_alu_result;
      fwd_memwb: rs2_val = wb_data;
      default:   rs2_val = ex_rs2_data;
    endcase
  end

  // LUI and AUIPC bypass the forwarded rs1
  assign op_a = (ex_opcode == op_lui)   ? '0 :
                (ex_opcode == op_auipc) ? ex_pc : rs1_val;
  assign op_b = ex_alu_src_imm ? ex_imm : rs2_val;

  // ====================================================================
  // ALU and branch
  // ====================================================================
  always_comb begin
    case (ex_alu_op)
      alu_sub:  alu_result = op_a - op_b;
      alu_sll:  alu_result = op_a << op_b[4:0];
      alu_slt:  alu_result = xlen'($signed(op_a) < $signed(op_b));
      alu_sltu: alu_result = xlen'(op_a < op_b);
      alu_xor:  alu_result = op_a ^ op_b;
      alu_srl:  alu_result = op_a >> op_b[4:0];
      alu_sra:  alu_result = $signed(op_a) >>> op_b[4:0];
      alu_or:   alu_result = op_a | op_b;
      alu_and:  alu_result = op_a & op_b;
      default:  alu_result = op_a + op_b;  // alu_add
    endcase
  end

  always_comb begin
    case (ex_funct3)
      3'b000:  take = rs1_val == rs2_val;                    // BEQ
      3'b001:  take = rs1_val != rs2_val;                    // BNE
      3'b100:  take = $signed(rs1_val) < $signed(rs2_val);   // BLT
      3'b101:  take = $signed(rs1_val) >= $signed(rs2_val);  // BGE
      3'b110:  take = rs1_val < rs2_val;                     // BLTU
      3'b111:  take = rs1_val >= rs2_val;                    // BGEU
      default: take = 1'b0;
    endcase
  end

  assign redirect = ex_valid && (ex_opcode == op_jal || ex_opcode == op_jalr ||
                                 (ex_opcode == op_branch && take));

  // JALR clears bit 0, branches and JAL are PC relative
  assign redirect_target = (ex_opcode == op_jalr) ? ((rs1_val + ex_imm) & ~xlen'(1)) :
                                                    ex_pc + ex_imm;

  // ====================================================================
  // EX/MEM register
  // ====================================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n)
      mem_valid <= 1'b0;
    else
      mem_valid <= ex_valid;
  end

  always_ff @(posedge clk) begin
    mem_alu_result <= alu_result;
    mem_store_data <= rs2_val;  // Forwarded store data
    mem_rd         <= ex_rd;
    mem_read       <= ex_mem_read;
    mem_write      <= ex_mem_write;
    mem_reg_write  <= ex_reg_write;
    mem_wb_sel     <= ex_wb_sel;
    mem_pc4        <= ex_pc + xlen'(4);  // Link value
  end

endmodule

// ==== rv_memory_stage.sv ====
// Memory stage
// Word data memory, write-back select and the MEM/WB register
`timescale 1ns/100ps

module rv_memory_stage import rv_pkg::*; (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic [xlen-1:0]          mem_alu_result,
  input  logic [xlen-1:0]          mem_store_data,
  input  logic [reg_addr_bits-1:0] mem_rd,
  input  logic                     mem_read,
  input  logic                     mem_write,
  input  logic                     mem_reg_write,
  input  logic [1:0]               mem_wb_sel,
  input  logic [xlen-1:0]          mem_pc4,
  input  logic                     mem_valid,
  output logic                     wb_valid,
  output logic [reg_addr_bits-1:0] wb_rd,
  output logic [xlen-1:0]          wb_data
);

  logic [xlen-1:0]           dmem [dmem_words];
  logic [dmem_addr_bits-1:0] dmem_idx;
  logic [xlen-1:0]           load_data;
  logic [xlen-1:0]           result;

  assign dmem_idx = mem_alu_result[dmem_addr_bits+1:2];  // Low two bits ignored

  always_ff @(posedge clk) begin
    if (mem_valid && mem_write)
      dmem[dmem_idx] <= mem_store_data;
  end

  assign load_data = mem_read ? dmem[dmem_idx] : '0;  // Combinational read

  // Write-back source
  always_comb begin
    case (mem_wb_sel)
      wb_mem:  result = load_data;
      wb_pc4:  result = mem_pc4;
      default: result = mem_alu_result;
    endcase
  end

  // MEM/WB, retirement only for real writes to x1..x31
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n)
      wb_valid <= 1'b0;
    else
      wb_valid <= mem_valid && mem_reg_write && mem_rd != '0;
  end

  always_ff @(posedge clk) begin
    wb_rd   <= mem_rd;
    wb_data <= result;
  end

endmodule

// ==== rv_core.sv ====
// Five-stage RV32I core top level
// Fetch, decode, execute and memory stages around the register file
`timescale 1ns/100ps

module rv_core import rv_pkg::*; (
  input  logic                     clk,
  input  logic                     reset_n,
  output logic [xlen-1:0]          imem_addr,
  input  logic [31:0]              imem_rdata,
  output logic                     wb_valid,
  output logic [reg_addr_bits-1:0] wb_rd,
  output logic [xlen-1:0]          wb_data
);

  // ====================================================================
  // Stage to stage wiring
  // ====================================================================
  logic                     stall;
  logic                     redirect;
  logic [xlen-1:0]          redirect_target;
  logic [xlen-1:0]          if_pc;
  logic [xlen-1:0]          if_instr;
  logic                     if_valid;
  logic [reg_addr_bits-1:0] rs1_addr;
  logic [reg_addr_bits-1:0] rs2_addr;
  logic [xlen-1:0]          rs1_data;
  logic [xlen-1:0]          rs2_data;

  // ID/EX
  logic [xlen-1:0]          ex_pc;
  logic [xlen-1:0]          ex_rs1_data;
  logic [xlen-1:0]          ex_rs2_data;
  logic [reg_addr_bits-1:0] ex_rs1;
  logic [reg_addr_bits-1:0] ex_rs2;
  logic [reg_addr_bits-1:0] ex_rd;
  logic [xlen-1:0]          ex_imm;
  logic [2:0]               ex_funct3;
  logic [3:0]               ex_alu_op;
  logic                     ex_alu_src_imm;
  logic [6:0]               ex_opcode;
  logic                     ex_mem_read;
  logic                     ex_mem_write;
  logic                     ex_reg_write;
  logic [1:0]               ex_wb_sel;
  logic                     ex_valid;

  // EX/MEM
  logic [xlen-1:0]          mem_alu_result;
  logic [xlen-1:0]          mem_store_data;
  logic [reg_addr_bits-1:0] mem_rd;
  logic                     mem_read;
  logic                     mem_write;
  logic                     mem_reg_write;
  logic [1:0]               mem_wb_sel;
  logic [xlen-1:0]          mem_pc4;
  logic                     mem_valid;

  // ====================================================================
  // Stages
  // ====================================================================
  rv_fetch fetch_inst (.*);

  rv_regfile regfile_inst (.*);  // Written from the MEM/WB triple

  rv_decode decode_inst (.*);

  rv_execute execute_inst (.*);

  rv_memory_stage memory_inst (.*);  // Drives the retirement port

endmodule

// ==== tb_clock.sv ====
// Testbench clock source
// Free running, 4 ns period
`timescale 1ns/100ps

module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // Half period
  end

endmodule

// ==== tb_core.sv ====
// Testbench top for the RV32I core
// Instruction memory model, program assembly, retirement checks
// Directed tests for ALU, forwarding, memory, control flow, upper immediates
`timescale 1ns/100ps

module tb_core import rv_pkg::*; ();

  logic                     clk;
  logic                     reset_n;
  logic [xlen-1:0]          imem_addr;
  logic [31:0]              imem_rdata;
  logic                     wb_valid;
  logic [reg_addr_bits-1:0] wb_rd;
  logic [xlen-1:0]          wb_data;

  logic [31:0] imem [256];
  logic [31:0] prog [$];      // Program under construction
  logic [4:0]  exp_rd [$];    // Expected retirements, in order
  logic [31:0] exp_data [$];
  int          seed = 32'h8ad5;

  tb_clock clock_inst (.clk(clk));

  rv_core rv_core_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .imem_addr (imem_addr),
    .imem_rdata(imem_rdata),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data)
  );

  assign imem_rdata = imem[imem_addr[9:2]];  // Answers in the same cycle

  // ====================================================================
  // Instruction encoders
  // ====================================================================
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input int rd, input int rs1, input int rs2);
    rv_instr_t w;
    w.r.funct7 = f7;
    w.r.rs2    = 5'(rs2);
    w.r.rs1    = 5'(rs1);
    w.r.funct3 = f3;
    w.r.rd     = 5'(rd);
    w.r.opcode = op_op;
    return w;
  endfunction

  function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                         input int rd, input int rs1, input logic [31:0] imm);
    rv_instr_t w;
    w.i.imm_11_0 = imm[11:0];
    w.i.rs1      = 5'(rs1);
    w.i.funct3   = f3;
    w.i.rd       = 5'(rd);
    w.i.opcode   = op;
    return w;
  endfunction

  function automatic logic [31:0] s_type(input int rs2, input int rs1, input logic [31:0] off);
    rv_instr_t w;
    w.s.imm_11_5 = off[11:5];
    w.s.rs2      = 5'(rs2);
    w.s.rs1      = 5'(rs1);
    w.s.funct3   = 3'b010;  // SW
    w.s.imm_4_0  = off[4:0];
    w.s.opcode   = op_store;
    return w;
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] f3, input int rs1, input int rs2,
                                         input logic [31:0] off);
    rv_instr_t w;
    w.b.imm_12   = off[12];
    w.b.imm_10_5 = off[10:5];
    w.b.rs2      = 5'(rs2);
    w.b.rs1      = 5'(rs1);
    w.b.funct3   = f3;
    w.b.imm_4_1  = off[4:1];
    w.b.imm_11   = off[11];
    w.b.opcode   = op_branch;
    return w;
  endfunction

  function automatic logic [31:0] u_type(input logic [6:0] op, input int rd,
                                         input logic [31:0] value);
    rv_instr_t w;
    w.u.imm_31_12 = value[31:12];
    w.u.rd        = 5'(rd);
    w.u.opcode    = op;
    return w;
  endfunction

  function automatic logic [31:0] j_type(input int rd, input logic [31:0] off);
    rv_instr_t w;
    w.j.imm_20    = off[20];
    w.j.imm_10_1  = off[10:1];
    w.j.imm_11    = off[11];
    w.j.imm_19_12 = off[19:12];
    w.j.rd        = 5'(rd);
    w.j.opcode    = op_jal;
    return w;
  endfunction

  // ====================================================================
  // Program building
  // ====================================================================
  task automatic emit(input logic [31:0] w);
    prog.push_back(w);
  endtask

  task automatic expect_wb(input int rd, input logic [31:0] value);
    exp_rd.push_back(5'(rd));
    exp_data.push_back(value);
  endtask

  function automatic logic [31:0] next_pc();
    return 32'(prog.size() * 4);
  endfunction

  task automatic nop();
    emit(i_type(op_op_imm, 3'b000, 0, 0, 32'h0));  // ADDI x0, x0, 0
  endtask

  // LUI plus ADDI, upper part rounded for the signed low half
  task automatic load_const(input int rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    emit(u_type(op_lui, rd, upper));
    expect_wb(rd, {upper[31:12], 12'b0});
    emit(i_type(op_op_imm, 3'b000, rd, rd, value));
    expect_wb(rd, value);
  endtask

  task automatic alu_rr(input logic [6:0] f7, input logic [2:0] f3, input int rd,
                        input int rs1, input int rs2, input logic [31:0] value);
    emit(r_type(f7, f3, rd, rs1, rs2));
    expect_wb(rd, value);
  endtask

  task automatic alu_ri(input logic [2:0] f3, input int rd, input int rs1,
                        input logic [31:0] imm, input logic [31:0] value);
    emit(i_type(op_op_imm, f3, rd, rs1, imm));
    expect_wb(rd, value);
  endtask

  task automatic load_word(input int rd, input int rs1, input logic [31:0] off,
                           input logic [31:0] value);
    emit(i_type(op_load, 3'b010, rd, rs1, off));
    expect_wb(rd, value);
  endtask

  // Branch shadow, never retires
  task automatic emit_shadow();
    emit(i_type(op_op_imm, 3'b000, 10, 0, 32'hfff));
    emit(i_type(op_op_imm, 3'b000, 11, 0, 32'hffe));
  endtask

  // ====================================================================
  // Run and check
  // ====================================================================
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Unwritten words hold JAL x0, 0
  task automatic load_imem();
    for (int i = 0; i < 256; i++)
      imem[8'(i)] = j_type(0, 32'h0);
    foreach (prog[i])
      imem[8'(i)] = prog[i];
  endtask

  task automatic run_program(input string name);
    int idx;
    int cycles;
    @(posedge clk);
    #1 reset_n = 1'b0;
    load_imem();
    repeat (16) @(posedge clk);
    #1 reset_n = 1'b1;
    idx    = 0;
    cycles = 0;
    while (idx < exp_rd.size()) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > 200)
        abort_run($sformatf("Test %s timed out with %0d of %0d register writes retired",
                            name, idx, exp_rd.size()));
      if (wb_valid) begin
        assert (wb_rd == exp_rd[idx] && wb_data == exp_data[idx]) else
          abort_run($sformatf("[FAIL] %s write %0d expected x%0d=%h actual x%0d=%h",
                              name, idx, exp_rd[idx], exp_data[idx], wb_rd, wb_data));
        idx++;
      end
    end
    prog.delete();
    exp_rd.delete();
    exp_data.delete();
  endtask

  // ====================================================================
  // Directed tests
  // ====================================================================
  task automatic test_alu();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    a   = $random(seed);
    b   = $random(seed);
    imm = $random(seed);
    imm = {{20{imm[11]}}, imm[11:0]};  // Sign-extended 12-bit immediate
    load_const(1, a);
    load_const(2, b);
    alu_rr(7'h00, 3'b000, 3, 1, 2, a + b);
    alu_rr(7'h20, 3'b000, 4, 1, 2, a - b);
    alu_rr(7'h00, 3'b001, 5, 1, 2, a << b[4:0]);
    alu_rr(7'h00, 3'b010, 6, 1, 2, {31'b0, $signed(a) < $signed(b)});
    alu_rr(7'h00, 3'b011, 7, 1, 2, {31'b0, a < b});
    alu_rr(7'h00, 3'b100, 8, 1, 2, a ^ b);
    alu_rr(7'h00, 3'b101, 9, 1, 2, a >> b[4:0]);
    alu_rr(7'h20, 3'b101, 10, 1, 2, $signed(a) >>> b[4:0]);
    alu_rr(7'h00, 3'b110, 11, 1, 2, a | b);
    alu_rr(7'h00, 3'b111, 12, 1, 2, a & b);
    alu_ri(3'b000, 13, 1, imm, a + imm);
    alu_ri(3'b010, 14, 1, imm, {31'b0, $signed(a) < $signed(imm)});
    alu_ri(3'b011, 15, 1, imm, {31'b0, a < imm});  // SLTIU compares the extended value
    alu_ri(3'b100, 16, 1, imm, a ^ imm);
    alu_ri(3'b110, 17, 1, imm, a | imm);
    alu_ri(3'b111, 18, 1, imm, a & imm);
    alu_ri(3'b001, 19, 1, {27'b0, imm[4:0]}, a << imm[4:0]);
    alu_ri(3'b101, 20, 1, {27'b0, imm[4:0]}, a >> imm[4:0]);
    alu_ri(3'b101, 21, 1, {20'b0, 7'h20, imm[4:0]}, $signed(a) >>> imm[4:0]);  // SRAI
    run_program("alu");
  endtask

  task automatic test_forwarding();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] s;
    a = $random(seed);
    b = $random(seed);
    s = a + b;
    load_const(1, a);
    load_const(2, b);
    alu_rr(7'h00, 3'b000, 3, 1, 2, s);
    alu_rr(7'h00, 3'b000, 4, 3, 1, s + a);      // Back to back
    alu_rr(7'h20, 3'b000, 5, 4, 3, a);          // EX/MEM and MEM/WB at once
    alu_rr(7'h00, 3'b100, 6, 1, 2, a ^ b);
    nop();
    alu_rr(7'h20, 3'b000, 7, 6, 2, (a ^ b) - b);  // One apart
    alu_rr(7'h00, 3'b110, 8, 1, 2, a | b);
    nop();
    nop();
    alu_rr(7'h00, 3'b111, 9, 8, 1, (a | b) & a);  // Two apart, regfile bypass
    alu_ri(3'b100, 10, 9, 32'h0ff, ((a | b) & a) ^ 32'h0ff);
    run_program("forwarding");
  endtask

  task automatic test_memory();
    logic [31:0] base;
    logic [31:0] d;
    logic [31:0] e;
    base = 32'h40 + ($random(seed) & 32'h1fc);  // Word aligned, room for -4 and +4
    d    = $random(seed);
    e    = $random(seed);
    load_const(1, base);
    load_const(2, d);
    load_const(3, e);
    emit(s_type(2, 1, 32'h0));
    emit(s_type(3, 1, 32'h4));
    load_word(4, 1, 32'h0, d);
    load_word(5, 1, 32'h4, e);
    alu_rr(7'h00, 3'b000, 6, 5, 4, d + e);  // Load-use on x5
    emit(s_type(6, 1, -32'sd4));            // Store data from EX/MEM
    load_word(7, 1, -32'sd4, d + e);
    alu_rr(7'h20, 3'b000, 8, 7, 2, e);
    run_program("memory");
  endtask

  task automatic test_control();
    logic [31:0] a;
    logic [31:0] here;
    logic [31:0] target;
    a = $random(seed);
    load_const(1, a);
    load_const(2, a);
    load_const(3, a ^ 32'h1);  // Differs from x1 in bit 0
    emit(b_type(3'b000, 1, 2, 32'd12));  // BEQ taken
    emit_shadow();
    alu_ri(3'b000, 12, 0, 32'd3, 32'd3);
    emit(b_type(3'b001, 1, 3, 32'd12));  // BNE taken
    emit_shadow();
    alu_ri(3'b000, 13, 0, 32'd4, 32'd4);
    emit(b_type(3'b000, 1, 3, 32'd12));  // BEQ not taken
    alu_ri(3'b000, 14, 0, 32'd5, 32'd5);
    alu_ri(3'b000, 15, 0, 32'd6, 32'd6);
    here = next_pc();
    emit(j_type(5, 32'd12));
    expect_wb(5, here + 32'd4);
    emit_shadow();
    alu_ri(3'b000, 16, 0, 32'd7, 32'd7);
    here   = next_pc();
    target = here + 32'd16;  // Past ADDI, JALR and the shadow
    alu_ri(3'b000, 6, 0, target, target);
    emit(i_type(op_jalr, 3'b000, 7, 6, 32'd1));  // Odd sum, bit 0 dropped
    expect_wb(7, here + 32'd8);
    emit_shadow();
    alu_ri(3'b000, 17, 0, 32'd8, 32'd8);
    run_program("control");
  endtask

  task automatic test_upper();
    logic [31:0] u;
    logic [31:0] here;
    u = $random(seed);
    emit(u_type(op_lui, 1, u));
    expect_wb(1, {u[31:12], 12'b0});
    here = next_pc();
    emit(u_type(op_auipc, 2, u));
    expect_wb(2, here + {u[31:12], 12'b0});
    emit(u_type(op_lui, 0, u));                // x0 writes never retire
    emit(r_type(7'h00, 3'b000, 0, 1, 2));
    alu_rr(7'h00, 3'b000, 3, 0, 1, {u[31:12], 12'b0});
    alu_rr(7'h00, 3'b110, 4, 0, 0, 32'h0);
    alu_ri(3'b000, 5, 0, 32'hfff, 32'hffff_ffff);
    run_program("upper_x0");
  endtask

  initial begin
    reset_n = 1'b0;
    load_imem();
    test_alu();
    test_forwarding();
    test_memory();
    test_control();
    test_upper();
    $display("No errors");
    $finish;
  end

endmodule

// ==== verilog.f ====
rv_pkg.sv
rv_fetch.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_memory_stage.sv
rv_core.sv
tb_clock.sv
tb_core.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
verilator --binary --timing --assert -j 0 --top-module tb_core -f verilog.f \
  && ./obj_dir/Vtb_core | tee /dev/stderr | grep -q "No errors" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
